/* dv/memTagShimTb.sv */
/*
 * Testbench for the read-request tagging shim
 * Random client reads, out-of-order memory, scoreboard keyed by memory tag
 */

`timescale 1ns/1ns

`include "tagShim_settings.svh"

module memTagShimTb
    import tagShimPkg::*;
();

    localparam int CLK_PERIOD = 100;
    localparam int RESET_CYCLES = 10;
    localparam int N_REQ = 400;
    localparam int N_CH = `NUM_RSP_CHANNELS;
    localparam int N_ENT = `TAG_HEAP_ENTRIES;
    localparam int MIN_FREE = `TAG_MIN_FREE;
    localparam int TIMEOUT = N_REQ * 20 * CLK_PERIOD;
    localparam logic [`DATA_BITS-1:0] DATA_MASK = 32'hA5A5_5A5A;

    logic       clk;
    logic       reset_n;
    logic       reqValid;
    clientReq_t req;
    logic       reqReady;
    logic       memReqValid;
    memReq_t    memReq;
    logic       memRspValid [N_CH];
    memRsp_t    memRsp [N_CH];
    logic       rspValid [N_CH];
    clientRsp_t rsp [N_CH];

    // Scoreboard indexed by memory tag
    clientReq_t expected [N_ENT];
    logic       busy [N_ENT];
    tagIdx_t    releaseQ [$];
    tagIdx_t    modelPtr;
    int         sentCount;
    int         rspCount;
    int         outstanding;
    integer     seed;

    // Inputs as seen by the DUT at the last rising edge
    logic       capReqValid;
    clientReq_t capReq;
    logic       capMemRspValid [N_CH];
    memRsp_t    capMemRsp [N_CH];

    memTagShim UUT
    (
        .clk,
        .reset_n,
        .reqValid,
        .req,
        .reqReady,
        .memReqValid,
        .memReq,
        .memRspValid,
        .memRsp,
        .rspValid,
        .rsp
    );

    tbOooMemory memory
    (
        .clk,
        .reset_n,
        .memReqValid,
        .memReq,
        .memRspValid,
        .memRsp
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    always @(posedge clk)
    begin
        capReqValid = reqValid;
        capReq = req;
        for (int c = 0; c < N_CH; c++)
        begin
            capMemRspValid[c] = memRspValid[c];
            capMemRsp[c] = memRsp[c];
        end
    end

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    // ========================================================================
    // Stimulus and per-cycle checks on the falling edge
    // ========================================================================

    task automatic driveRequest();
        logic [31:0] rnd;
        if (sentCount < N_REQ && reqReady && ($unsigned($random(seed)) % 4) != 0)
        begin
            rnd = $random(seed);
            req.userTag = rnd[`USER_TAG_BITS-1:0];
            req.addr = $random(seed);
            reqValid = 1'b1;
            sentCount++;
        end
        else
        begin
            reqValid = 1'b0;
        end
    endtask

    task automatic checkCycle();
        tagIdx_t    t;
        clientReq_t e;
        logic       expReady;
        // Slots answered last cycle were released at the edge just passed
        while (releaseQ.size() > 0)
        begin
            t = releaseQ.pop_front();
            busy[t] = 1'b0;
        end
        if (capReqValid)
        begin
            assert (memReqValid === 1'b1)
                else failRun("memReqValid missing one cycle after a request strobe");
            assert (memReq.addr === capReq.addr)
                else failRun($sformatf("mismatch memReq.addr: expected %h, got %h",
                    capReq.addr, memReq.addr));
            assert (memReq.tag === modelPtr)
                else failRun($sformatf("mismatch memReq.tag: expected %h, got %h",
                    modelPtr, memReq.tag));
            assert (!busy[memReq.tag])
                else failRun("memory tag issued while still outstanding");
            expected[memReq.tag] = capReq;
            busy[memReq.tag] = 1'b1;
            outstanding++;
            modelPtr = tagIdx_t'((int'(modelPtr) + 1) % N_ENT);
        end
        else
        begin
            assert (memReqValid === 1'b0)
                else failRun("memReqValid seen without a request strobe");
        end
        for (int c = 0; c < N_CH; c++)
        begin
            if (capMemRspValid[c])
            begin
                t = capMemRsp[c].tag;
                e = expected[t];
                assert (rspValid[c] === 1'b1)
                    else failRun($sformatf("rspValid[%0d] missing after memRspValid", c));
                assert (rsp[c].userTag === e.userTag)
                    else failRun($sformatf("mismatch rsp[%0d].userTag: expected %h, got %h",
                        c, e.userTag, rsp[c].userTag));
                assert (rsp[c].addr === e.addr)
                    else failRun($sformatf("mismatch rsp[%0d].addr: expected %h, got %h",
                        c, e.addr, rsp[c].addr));
                assert (rsp[c].data === (e.addr ^ DATA_MASK))
                    else failRun($sformatf("mismatch rsp[%0d].data: expected %h, got %h",
                        c, e.addr ^ DATA_MASK, rsp[c].data));
                releaseQ.push_back(t);
                outstanding--;
                rspCount++;
            end
            else
            begin
                assert (rspValid[c] === 1'b0)
                    else failRun($sformatf("rspValid[%0d] seen without a memory response", c));
            end
        end
        assert (outstanding <= N_ENT)
            else failRun("more tags outstanding than heap entries");
        // Ready only while the window ahead of the pointer is free
        expReady = 1'b1;
        for (int i = 0; i < MIN_FREE; i++)
        begin
            if (busy[(int'(modelPtr) + i) % N_ENT])
            begin
                expReady = 1'b0;
            end
        end
        assert (reqReady === expReady)
            else failRun($sformatf("mismatch reqReady: expected %h, got %h",
                expReady, reqReady));
    endtask

    // ========================================================================
    // Main sequence
    // ========================================================================

    initial
    begin
        seed = 62;
        reset_n = 1'b0;
        reqValid = 1'b0;
        req = '0;
        modelPtr = '0;
        sentCount = 0;
        rspCount = 0;
        outstanding = 0;
        for (int i = 0; i < N_ENT; i++)
        begin
            busy[i] = 1'b0;
        end

        repeat (RESET_CYCLES) @(negedge clk);
        reset_n = 1'b1;
        assert (reqReady === 1'b1)
            else failRun("reqReady low right after reset");
        assert (memReqValid === 1'b0)
            else failRun("memReqValid high right after reset");
        for (int c = 0; c < N_CH; c++)
        begin
            assert (rspValid[c] === 1'b0)
                else failRun($sformatf("rspValid[%0d] high right after reset", c));
        end

        driveRequest();
        while (rspCount < N_REQ)
        begin
            @(negedge clk);
            checkCycle();
            driveRequest();
        end

        // Let the last frees land and confirm the outputs stay quiet
        repeat (3)
        begin
            @(negedge clk);
            checkCycle();
        end
        assert (sentCount == N_REQ && rspCount == N_REQ && outstanding == 0)
            else failRun("request and response counts differ after draining");
        assert (reqReady === 1'b1)
            else failRun("reqReady still low after draining");

        $display("=== PASS ===");
        $finish;
    end

    // Watchdog sized from the request count
    initial
    begin
        #(TIMEOUT);
        failRun("timeout waiting for all responses to return");
    end

endmodule

/* dv/tbOooMemory.sv */
/*
 * Out-of-order memory model for the tagging shim testbench
 * Records tagged reads and returns them in random order on random channels
 */

`timescale 1ns/1ns

`include "tagShim_settings.svh"

module tbOooMemory
    import tagShimPkg::*;
#(
    parameter int SEED = 62
)
(
    input  logic    clk,
    input  logic    reset_n,

    // Tagged reads from the DUT
    input  logic    memReqValid,
    input  memReq_t memReq,

    // Responses toward the DUT, one per channel
    output logic    memRspValid [`NUM_RSP_CHANNELS],
    output memRsp_t memRsp [`NUM_RSP_CHANNELS]
);

    // Read data is the address scrambled with a fixed pattern
    localparam logic [`DATA_BITS-1:0] DATA_MASK = 32'hA5A5_5A5A;

    // Reads waiting for a response
    memReq_t pending [$];
    integer  seed;

    initial
    begin
        int      pick;
        memReq_t entry;

        seed = SEED;
        for (int c = 0; c < `NUM_RSP_CHANNELS; c++)
        begin
            memRspValid[c] = 1'b0;
            memRsp[c] = '0;
        end

        forever
        begin
            @(negedge clk);
            if (!reset_n)
            begin
                pending.delete();
            end
            else
            begin
                // Request issued at the last edge becomes outstanding
                if (memReqValid)
                begin
                    pending.push_back(memReq);
                end
                for (int c = 0; c < `NUM_RSP_CHANNELS; c++)
                begin
                    memRspValid[c] = 1'b0;
                    memRsp[c] = '0;
                    // Popping the entry keeps the two channels on distinct tags
                    if (pending.size() > 0 && ($unsigned($random(seed)) % 8) < 3)
                    begin
                        pick = $unsigned($random(seed)) % pending.size();
                        entry = pending[pick];
                        pending.delete(pick);
                        memRspValid[c] = 1'b1;
                        memRsp[c].tag = entry.tag;
                        memRsp[c].data = entry.addr ^ DATA_MASK;
                    end
                end
            end
        end
    end

endmodule

/* hdl/memTagShim.sv */
/*
 * Top level of the read-request tagging shim
 * Tagger, shared heap and one response matcher per memory channel
 */

`timescale 1ns/1ns

`include "tagShim_settings.svh"

module memTagShim
    import tagShimPkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    // Client request side
    input  logic       reqValid,
    input  clientReq_t req,
    output logic       reqReady,

    // Memory request side
    output logic       memReqValid,
    output memReq_t    memReq,

    // Memory response channels
    input  logic       memRspValid [`NUM_RSP_CHANNELS],
    input  memRsp_t    memRsp [`NUM_RSP_CHANNELS],

    // Client response channels, same numbering as memory
    output logic       rspValid [`NUM_RSP_CHANNELS],
    output clientRsp_t rsp [`NUM_RSP_CHANNELS]
);

    // Allocation side of the heap
    logic     heapEnq;
    reqMeta_t heapEnqData;
    logic     heapNotFull;
    tagIdx_t  heapAllocIdx;

    // Read and free side, one entry per channel
    tagIdx_t  heapReadReq [`NUM_RSP_CHANNELS];
    reqMeta_t heapReadRsp [`NUM_RSP_CHANNELS];
    logic     heapFree [`NUM_RSP_CHANNELS];
    tagIdx_t  heapFreeIdx [`NUM_RSP_CHANNELS];

    reqTagger tagger
    (
        .clk,
        .reset_n,
        .reqValid,
        .req,
        .reqReady,
        .heapNotFull(heapNotFull),
        .allocIdx(heapAllocIdx),
        .enq(heapEnq),
        .enqMeta(heapEnqData),
        .memReqValid,
        .memReq
    );

    tagHeap
    #(
        .N_ENTRIES(`TAG_HEAP_ENTRIES),
        .N_DATA_BITS($bits(reqMeta_t)),
        .N_READ_PORTS(`NUM_RSP_CHANNELS),
        .MIN_FREE_SLOTS(`TAG_MIN_FREE)
    )
    heap
    (
        .clk,
        .reset_n,
        .enq(heapEnq),
        .enqData(heapEnqData),
        .notFull(heapNotFull),
        .allocIdx(heapAllocIdx),
        .readReq(heapReadReq),
        .readRsp(heapReadRsp),
        .free(heapFree),
        .freeIdx(heapFreeIdx)
    );

    // One matcher per response channel
    for (genvar c = 0; c < `NUM_RSP_CHANNELS; c++)
    begin : gMatch
        rspMatcher matcher
        (
            .clk,
            .reset_n,
            .memRspValid(memRspValid[c]),
            .memRsp(memRsp[c]),
            .readReq(heapReadReq[c]),
            .readMeta(heapReadRsp[c]),
            .free(heapFree[c]),
            .freeIdx(heapFreeIdx[c]),
            .rspValid(rspValid[c]),
            .rsp(rsp[c])
        );
    end

endmodule

/* hdl/reqTagger.sv */
/*
 * Client request tagger
 * Claims a heap slot per request and issues the tagged memory read
 */

`timescale 1ns/1ns

module reqTagger
    import tagShimPkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    // Client request strobe
    input  logic       reqValid,
    input  clientReq_t req,
    output logic       reqReady,

    // Heap allocation side
    input  logic       heapNotFull,
    input  tagIdx_t    allocIdx,
    output logic       enq,
    output reqMeta_t   enqMeta,

    // Tagged request toward memory
    output logic       memReqValid,
    output memReq_t    memReq
);

    // Client may strobe only while the heap keeps its free window
    assign reqReady = heapNotFull;

    // Every accepted request claims the slot under the pointer
    assign enq = reqValid;

    always_comb
    begin
        enqMeta.userTag = req.userTag;
        enqMeta.addr = req.addr;
    end

    // ========================================================================
    // Memory request, issued the cycle after the strobe
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            memReqValid <= 1'b0;
        end
        else
        begin
            memReqValid <= reqValid;
        end
    end

    // Slot index becomes the memory tag
    always_ff @(posedge clk)
    begin
        if (reqValid)
        begin
            memReq.tag <= allocIdx;
            memReq.addr <= req.addr;
        end
    end

    // Client strobed without seeing reqReady
    reqWhileFull: assert property (@(posedge clk) disable iff (!reset_n)
        reqValid |-> heapNotFull);

endmodule

/* hdl/rspMatcher.sv */
/*
 * Response matcher for one memory response channel
 * Looks up the heap by memory tag, rebuilds the client response
 * and releases the slot
 */

`timescale 1ns/1ns

module rspMatcher
    import tagShimPkg::*;
(
    input  logic       clk,
    input  logic       reset_n,

    // Memory response on this channel
    input  logic       memRspValid,
    input  memRsp_t    memRsp,

    // Heap read port, metadata one cycle after readReq
    output tagIdx_t    readReq,
    input  reqMeta_t   readMeta,

    // Heap free port
    output logic       free,
    output tagIdx_t    freeIdx,

    // Client response on this channel
    output logic       rspValid,
    output clientRsp_t rsp
);

    // Response held for the heap read cycle
    logic    rspValidQ;
    tagIdx_t tagQ;
    logic [$bits(memRsp.data)-1:0] dataQ;

    // Tag addresses the heap directly, lookup overlaps the holding cycle
    assign readReq = memRsp.tag;

    // ========================================================================
    // One-cycle hold
    // ========================================================================

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            rspValidQ <= 1'b0;
        end
        else
        begin
            rspValidQ <= memRspValid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (memRspValid)
        begin
            tagQ <= memRsp.tag;
            dataQ <= memRsp.data;
        end
    end

    // ========================================================================
    // Client response and slot release
    // ========================================================================

    assign rspValid = rspValidQ;

    // Slot reusable from the cycle after the response leaves
    assign free = rspValidQ;
    assign freeIdx = tagQ;

    always_comb
    begin
        rsp.userTag = readMeta.userTag;
        rsp.addr = readMeta.addr;
        rsp.data = dataQ;
    end

endmodule

/* hdl/tagHeap.sv */
/*
 * Round-robin heap with a single allocation port
 * Per-read-port replicated data memories, one-cycle reads
 * Per-port free of slots, early full with a minimum free window
 */

`timescale 1ns/1ns

module tagHeap
#(
    parameter int N_ENTRIES = 16,
    parameter int N_DATA_BITS = 44,
    parameter int N_READ_PORTS = 2,
    // Slots ahead of the pointer that must be free for notFull
    parameter int MIN_FREE_SLOTS = 2,
    localparam int IDX_BITS = $clog2(N_ENTRIES)
)
(
    input  logic clk,
    input  logic reset_n,

    // Allocation port, data written into the slot under allocIdx
    input  logic                   enq,
    input  logic [N_DATA_BITS-1:0] enqData,
    output logic                   notFull,
    output logic [IDX_BITS-1:0]    allocIdx,

    // Read ports, data returned one cycle after the index
    input  logic [IDX_BITS-1:0]    readReq [N_READ_PORTS],
    output logic [N_DATA_BITS-1:0] readRsp [N_READ_PORTS],

    // Free ports, one per read port
    input  logic                   free [N_READ_PORTS],
    input  logic [IDX_BITS-1:0]    freeIdx [N_READ_PORTS]
);

    // One bit per slot, set while the slot is available
    logic [N_ENTRIES-1:0] slotFree;

    // Round-robin allocation pointer
    logic [IDX_BITS-1:0] allocPtr;

    // Low slot bits appended above the top so the window never wraps
    logic [N_ENTRIES+MIN_FREE_SLOTS-1:0] wrapFree;

    // ========================================================================
    // Allocation
    // ========================================================================

    assign allocIdx = allocPtr;
    assign wrapFree = {slotFree[MIN_FREE_SLOTS-1:0], slotFree};

    // Full is declared early, when any slot of the window is still busy
    assign notFull = &wrapFree[allocPtr +: MIN_FREE_SLOTS];

    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            allocPtr <= '0;
        end
        else if (enq)
        begin
            // Step to the next slot, wrapping at the last entry
            allocPtr <= (allocPtr == IDX_BITS'(N_ENTRIES - 1)) ?
                        '0 : allocPtr + 1'b1;
        end
    end

    // Busy tracking, enq claims and each port may release
    always_ff @(posedge clk)
    begin
        if (!reset_n)
        begin
            slotFree <= '1;
        end
        else
        begin
            if (enq)
            begin
                slotFree[allocPtr] <= 1'b0;
            end
            for (int i = 0; i < N_READ_PORTS; i++)
            begin
                if (free[i])
                begin
                    slotFree[freeIdx[i]] <= 1'b1;
                end
            end
        end
    end

    // ========================================================================
    // Data memories, one copy per read port
    // ========================================================================

    for (genvar p = 0; p < N_READ_PORTS; p++)
    begin : gMem
        logic [N_DATA_BITS-1:0] mem [N_ENTRIES];

        always_ff @(posedge clk)
        begin
            // Registered read, valid in the following cycle
            readRsp[p] <= mem[readReq[p]];
            if (enq)
            begin
                mem[allocPtr] <= enqData;
            end
        end
    end

    // ========================================================================
    // Checks
    // ========================================================================

    // Requester must respect notFull, so the pointer slot is never busy
    enqIntoFreeSlot: assert property (@(posedge clk) disable iff (!reset_n)
        enq |-> slotFree[allocPtr]);

    for (genvar p = 0; p < N_READ_PORTS; p++)
    begin : gFreeCheck
        // A slot is released only once per allocation
        freeOfBusySlot: assert property (@(posedge clk) disable iff (!reset_n)
            free[p] |-> !slotFree[freeIdx[p]]);

        // Two channels never release the same slot together
        for (genvar q = p + 1; q < N_READ_PORTS; q++)
        begin : gPair
            distinctFree: assert property (@(posedge clk) disable iff (!reset_n)
                (free[p] && free[q]) |-> (freeIdx[p] != freeIdx[q]));
        end
    end

endmodule

/* hdl/tagShimPkg.sv */
/*
 * Shared types of the read-request tagging shim
 * Client request/response, heap metadata and memory-side request/response
 */

`include "tagShim_settings.svh"

package tagShimPkg;

    // Heap slot index, also used as the memory tag
    typedef logic [`TAG_IDX_BITS-1:0] tagIdx_t;

    // Client read request
    typedef struct packed {
        logic [`USER_TAG_BITS-1:0] userTag;
        logic [`ADDR_BITS-1:0]     addr;
    } clientReq_t;

    // Per-slot metadata held in the heap until the response returns
    typedef struct packed {
        logic [`USER_TAG_BITS-1:0] userTag;
        logic [`ADDR_BITS-1:0]     addr;
    } reqMeta_t;

    // Request toward memory, tagged with the heap index
    typedef struct packed {
        tagIdx_t               tag;
        logic [`ADDR_BITS-1:0] addr;
    } memReq_t;

    // Response from memory on one channel
    typedef struct packed {
        tagIdx_t               tag;
        logic [`DATA_BITS-1:0] data;
    } memRsp_t;

    // Response back to the client, metadata rejoined with read data
    typedef struct packed {
        logic [`USER_TAG_BITS-1:0] userTag;
        logic [`ADDR_BITS-1:0]     addr;
        logic [`DATA_BITS-1:0]     data;
    } clientRsp_t;

endpackage

/* hdl/tagShim_settings.svh */
/*
 * Build settings for the read-request tagging shim
 * Heap depth, full threshold, response channel count and field widths
 */

`ifndef TAGSHIM_SETTINGS_SVH
`define TAGSHIM_SETTINGS_SVH

// Heap slots, one per outstanding memory read
`define TAG_HEAP_ENTRIES 16
// Free slots kept ahead of the pointer before reqReady drops
`define TAG_MIN_FREE 2
// Memory response channels, also heap read/free ports
`define NUM_RSP_CHANNELS 2

// Field widths
`define ADDR_BITS 32
`define DATA_BITS 32
`define USER_TAG_BITS 12
`define TAG_IDX_BITS $clog2(`TAG_HEAP_ENTRIES)

`endif

/* memTagShim.f */
+incdir+hdl
hdl/tagShimPkg.sv
hdl/tagHeap.sv
hdl/reqTagger.sv
hdl/rspMatcher.sv
hdl/memTagShim.sv
dv/tbOooMemory.sv
dv/memTagShimTb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Compiles and runs the memTagShim testbench with Verilator
# Exit status is nonzero when the build fails or the run reports failure

set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log
TOP=memTagShimTb

verilator --binary --timing --assert -Wno-fatal \
    -f memTagShim.f \
    --top-module "$TOP" \
    --Mdir "$BUILD_DIR" \
    -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

"./$BUILD_DIR/simv" > "$LOG_FILE" 2>&1
run_status=$?
cat "$LOG_FILE"

if grep -qF "=== FAIL ===" "$LOG_FILE"; then
    echo "Simulation reported a failure, see $LOG_FILE"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "Simulator exited with status $run_status"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
